// ==== tb.f ====
+incdir+hdl
hdl/dmb_cfg_pkg.sv
hdl/dmb_trig_pkg.sv
hdl/trig_cfg_if.sv
hdl/reset_sequencer.sv
hdl/wb_cfg_regs.sv
hdl/trig_enc_out.sv
hdl/lct_l1a_timer.sv
hdl/cal_pulse_cond.sv
hdl/dmb_ctrl_top.sv
verif/dmb_ctrl_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
	--top-module dmb_ctrl_tb --Mdir obj_dir -o dmb_ctrl_sim
out=$(./obj_dir/dmb_ctrl_sim)
echo "$out"
if echo "$out" | grep -q "^All tests passed$"; then
	exit 0
fi
exit 1

// ==== verif/dmb_ctrl_tb.sv ====
`timescale 1ns/1ps
`include "dmb_ctrl_macros.svh"

module dmb_ctrl_tb;

	localparam int CLK_HALF = 10;
	localparam int TRIG_N = 40;
	localparam int BUS_LEN = 4;
	localparam int BOOT_LEN = 3 + 3 * (`DMB_CRDY_CYCLES + 8) + `DMB_POH_CYCLES;
	localparam int REG_LEN = (2 * 8 + 2 * 12 + 6) * BUS_LEN;
	localparam int TRIG_LEN = 4 * (TRIG_N + 2 * BUS_LEN) + 20 + 4 * BUS_LEN;
	localparam int TIMER_LEN = 210 + 20 * (3 * BUS_LEN + 2) + 300 + 4 * BUS_LEN;
	localparam int CAL_LEN = 8 * 20;
	localparam int WATCHDOG_CYCLES =
		2 * (BOOT_LEN + REG_LEN + TRIG_LEN + TIMER_LEN + CAL_LEN);
	localparam logic [7:0] CFG_MASK = 8'((1 << `DMB_CFG_CABLE_DLY) |
		(1 << `DMB_CFG_DCFEB_IN_USE) | (1 << `DMB_CFG_PULSE_ALT));
	localparam logic [7:0] SOFT_RST_VAL = 8'(1 << `DMB_CTL_SOFT_RST);
	localparam logic [7:0] PULSE_ALT_VAL = 8'(1 << `DMB_CFG_PULSE_ALT);

	logic clkcms, rst, fpga_ready_i;
	logic wb_cyc_i, wb_stb_i, wb_we_i;
	logic [3:0] wb_adr_i;
	logic [7:0] wb_dat_i, wb_dat_o;
	logic wb_ack_o;
	logic [5:0] pre_lct_i;
	logic [5:1] l1a_match_i;
	logic l1a_cfeb_i, l1a_i;
	logic [2:1] ccbcal_i;
	logic [5:1] trg_enc_b0_o, trg_enc_b1_o, trg_enc_b2_o;
	logic inj_pulse_o, ext_pulse_o, ctrl_ready_o;

	int errors;
	integer seed;
	logic [31:0] rnd;
	logic [7:0] rdata;
	logic alt_gate_on;
	int highs;

	dmb_ctrl_top dut (.*);

	always #(CLK_HALF) clkcms = ~clkcms;

	//////////////////////////////
	// Protocol and output checks
	//////////////////////////////

	assert property (@(posedge clkcms) disable iff (rst) wb_ack_o |=> !wb_ack_o)
	else
	begin
		errors++;
		$display("Register bus acknowledge stayed high for more than one cycle");
	end

	// L1A bus never shows a partial pattern
	assert property (@(posedge clkcms) disable iff (rst)
		trg_enc_b1_o == 5'h00 || trg_enc_b1_o == 5'h1f)
	else
	begin
		errors++;
		$display("CHECK FAILED trg_enc_b1_o: got 0x%h, expected 0x00 or 0x1f",
			$sampled(trg_enc_b1_o));
	end

	assert property (@(posedge clkcms) disable iff (rst)
		alt_gate_on && ext_pulse_o |=> !ext_pulse_o)
	else
	begin
		errors++;
		$display("ext_pulse_o high on two consecutive cycles with alternating gate on");
	end

	task automatic expect_eq(input string name, input logic [7:0] got, input logic [7:0] want);
		assert (got === want)
		else
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
		end
	endtask

	//////////////////////////////
	// Wishbone access
	//////////////////////////////

	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
		int waited;
		waited = 0;
		@(posedge clkcms);
		#2;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		@(posedge clkcms);
		#1;
		while (!wb_ack_o && waited < 8)
		begin
			@(posedge clkcms);
			#1;
			waited++;
		end
		if (!wb_ack_o)
		begin
			errors++;
			$display("No acknowledge from register bus at address 0x%h", adr);
		end
		rdat = wb_dat_o;
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		@(posedge clkcms);
		#1;
	endtask

	task automatic write_reg(input logic [3:0] adr, input logic [7:0] data);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic read_reg(input logic [3:0] adr, output logic [7:0] data);
		bus_cycle(1'b0, adr, 8'h00, data);
	endtask

	//////////////////////////////
	// Test sequences
	//////////////////////////////

	task automatic raise_ready();
		int n;
		n = 0;
		@(posedge clkcms);
		#2;
		fpga_ready_i = 1'b1;
		while (!ctrl_ready_o && n < `DMB_CRDY_CYCLES + 4)
		begin
			@(posedge clkcms);
			#1;
			n++;
		end
		if (!ctrl_ready_o)
		begin
			errors++;
			$display("ctrl_ready_o did not rise after clock-ready went high");
		end
	endtask

	task automatic wait_holdoff_low();
		logic [7:0] sts;
		int tries;
		tries = 0;
		read_reg(`DMB_REG_STATUS, sts);
		while (sts[`DMB_STA_HOLDOFF] && tries < `DMB_POH_CYCLES)
		begin
			read_reg(`DMB_REG_STATUS, sts);
			tries++;
		end
		if (sts[`DMB_STA_HOLDOFF])
		begin
			errors++;
			$display("Power-on holdoff never cleared in STATUS");
		end
	endtask

	// Random trigger traffic with outputs compared after the latency
	task automatic run_trig(input logic cdly, input logic use_match);
		logic [7:0] cfg_val;
		logic [4:0] lct_h1, lct_h2, match_h1, match_h2;
		logic l1a_h1, l1a_h2;
		logic [4:0] want0;
		logic want1;
		int lat;
		cfg_val = '0;
		cfg_val[`DMB_CFG_CABLE_DLY] = cdly;
		cfg_val[`DMB_CFG_DCFEB_IN_USE] = use_match;
		lat = cdly ? 2 : 1;
		lct_h1 = '0;
		lct_h2 = '0;
		match_h1 = '0;
		match_h2 = '0;
		l1a_h1 = 1'b0;
		l1a_h2 = 1'b0;
		write_reg(`DMB_REG_CONFIG, cfg_val);
		for (int j = 0; j < TRIG_N; j++)
		begin
			@(posedge clkcms);
			#1;
			if (j >= lat)
			begin
				want0 = (lat == 1) ? (use_match ? match_h1 : lct_h1) :
					(use_match ? match_h2 : lct_h2);
				want1 = (lat == 1) ? l1a_h1 : l1a_h2;
				expect_eq("trg_enc_b0_o", 8'(trg_enc_b0_o), 8'(want0));
				expect_eq("trg_enc_b1_o", 8'(trg_enc_b1_o), want1 ? 8'h1f : 8'h00);
				expect_eq("trg_enc_b2_o", 8'(trg_enc_b2_o), 8'h00);
			end
			#1;
			rnd = $random(seed);
			lct_h2 = lct_h1;
			match_h2 = match_h1;
			l1a_h2 = l1a_h1;
			lct_h1 = rnd[4:0];
			match_h1 = rnd[9:5];
			l1a_h1 = rnd[10];
			pre_lct_i[5:1] = lct_h1;
			l1a_match_i = match_h1;
			l1a_cfeb_i = l1a_h1;
		end
		pre_lct_i = '0;
		l1a_match_i = '0;
		l1a_cfeb_i = 1'b0;
	endtask

	// LCT flag followed by L1A d cycles later
	task automatic time_lct_to_l1a(input int d);
		@(posedge clkcms);
		#2;
		pre_lct_i[0] = 1'b1;
		@(posedge clkcms);
		#2;
		pre_lct_i[0] = 1'b0;
		repeat (d - 1) @(posedge clkcms);
		#2;
		l1a_i = 1'b1;
		@(posedge clkcms);
		#2;
		l1a_i = 1'b0;
	endtask

	task automatic check_cal_line(input logic pulse_line, input int n);
		logic got;
		int last;
		string name;
		last = pulse_line ? n + 2 : n + 1;
		name = pulse_line ? "ext_pulse_o" : "inj_pulse_o";
		@(posedge clkcms);
		#2;
		if (pulse_line)
			ccbcal_i[1] = 1'b0;
		else
			ccbcal_i[2] = 1'b0;
		for (int j = 1; j <= n + 4; j++)
		begin
			@(posedge clkcms);
			#1;
			got = pulse_line ? ext_pulse_o : inj_pulse_o;
			expect_eq(name, 8'(got), (j >= 2 && j <= last) ? 8'h01 : 8'h00);
			#1;
			if (j == n)
				ccbcal_i = 2'b11;
		end
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clkcms);
		$display("Watchdog expired after %0d cycles, simulation stopped", WATCHDOG_CYCLES);
		$display("Errors: %0d", errors);
		$display("Some tests failed");
		$finish;
	end

	initial
	begin
		errors = 0;
		seed = 32'ha6df9fb1;
		clkcms = 1'b0;
		rst = 1'b1;
		fpga_ready_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		pre_lct_i = '0;
		l1a_match_i = '0;
		l1a_cfeb_i = 1'b0;
		l1a_i = 1'b0;
		ccbcal_i = 2'b11;
		alt_gate_on = 1'b0;

		// Outputs inactive while reset is held
		repeat (3) @(posedge clkcms);
		#1;
		expect_eq("wb_ack_o", 8'(wb_ack_o), 8'h00);
		expect_eq("ctrl_ready_o", 8'(ctrl_ready_o), 8'h00);
		expect_eq("trg_enc_b0_o", 8'(trg_enc_b0_o), 8'h00);
		expect_eq("trg_enc_b1_o", 8'(trg_enc_b1_o), 8'h00);
		expect_eq("trg_enc_b2_o", 8'(trg_enc_b2_o), 8'h00);
		expect_eq("inj_pulse_o", 8'(inj_pulse_o), 8'h00);
		expect_eq("ext_pulse_o", 8'(ext_pulse_o), 8'h00);
		#1;
		rst = 1'b0;
		@(posedge clkcms);
		#1;
		expect_eq("ctrl_ready_o", 8'(ctrl_ready_o), 8'h00);

		// Clock-ready up, down and up again
		raise_ready();
		read_reg(`DMB_REG_STATUS, rdata);
		expect_eq("STATUS ready", 8'(rdata[`DMB_STA_READY]), 8'h01);
		@(posedge clkcms);
		#2;
		fpga_ready_i = 1'b0;
		repeat (3) @(posedge clkcms);
		#1;
		expect_eq("ctrl_ready_o", 8'(ctrl_ready_o), 8'h00);
		read_reg(`DMB_REG_STATUS, rdata);
		expect_eq("STATUS ready", 8'(rdata[`DMB_STA_READY]), 8'h00);
		raise_ready();

		// Register read back
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			write_reg(`DMB_REG_CONFIG, rnd[7:0]);
			read_reg(`DMB_REG_CONFIG, rdata);
			expect_eq("CONFIG", rdata, rnd[7:0] & CFG_MASK);
		end
		for (int a = 4; a < 16; a++)
		begin
			write_reg(4'(a), 8'hff);
			read_reg(4'(a), rdata);
			expect_eq("unmapped register", rdata, 8'h00);
		end

		run_trig(1'b0, 1'b0);
		run_trig(1'b0, 1'b1);
		run_trig(1'b1, 1'b0);
		run_trig(1'b1, 1'b1);

		// Soft reset drives the resync bus
		write_reg(`DMB_REG_CONFIG, 8'h00);
		write_reg(`DMB_REG_CONTROL, SOFT_RST_VAL);
		read_reg(`DMB_REG_CONTROL, rdata);
		expect_eq("CONTROL", rdata, SOFT_RST_VAL);
		expect_eq("trg_enc_b2_o", 8'(trg_enc_b2_o), 8'h1f);
		write_reg(`DMB_REG_CONTROL, 8'h00);
		@(posedge clkcms);
		#1;
		expect_eq("trg_enc_b2_o", 8'(trg_enc_b2_o), 8'h00);

		//////////////////////////////
		// LCT to L1A timer
		//////////////////////////////
		wait_holdoff_low();
		write_reg(`DMB_REG_TIMER, 8'h00);
		for (int d = 1; d <= 20; d++)
		begin
			time_lct_to_l1a(d);
			read_reg(`DMB_REG_TIMER, rdata);
			expect_eq("TIMER", rdata, 8'(d));
			write_reg(`DMB_REG_TIMER, 8'h00);
		end
		time_lct_to_l1a(300);
		read_reg(`DMB_REG_TIMER, rdata);
		expect_eq("TIMER", rdata, 8'hff);
		write_reg(`DMB_REG_TIMER, 8'h00);
		read_reg(`DMB_REG_TIMER, rdata);
		expect_eq("TIMER", rdata, 8'h00);

		// Calibration lines
		check_cal_line(1'b0, 1);
		check_cal_line(1'b0, 3);
		check_cal_line(1'b0, 5);
		check_cal_line(1'b1, 1);
		check_cal_line(1'b1, 4);

		write_reg(`DMB_REG_CONFIG, PULSE_ALT_VAL);
		alt_gate_on = 1'b1;
		highs = 0;
		@(posedge clkcms);
		#2;
		ccbcal_i[1] = 1'b0;
		for (int j = 1; j <= 12; j++)
		begin
			@(posedge clkcms);
			#1;
			if (ext_pulse_o)
				highs++;
			#1;
			if (j == 6)
				ccbcal_i[1] = 1'b1;
		end
		if (highs == 0)
		begin
			errors++;
			$display("Gated calibration pulse never reached ext_pulse_o");
		end
		alt_gate_on = 1'b0;
		write_reg(`DMB_REG_CONFIG, 8'h00);

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== hdl/dmb_ctrl_top.sv ====
`timescale 1ns/1ps

module dmb_ctrl_top
(
	input  logic clkcms,
	input  logic rst,
	input  logic fpga_ready_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [3:0] wb_adr_i,
	input  logic [7:0] wb_dat_i,
	output logic [7:0] wb_dat_o,
	output logic wb_ack_o,
	input  logic [5:0] pre_lct_i,
	input  logic [5:1] l1a_match_i,
	input  logic l1a_cfeb_i,
	input  logic l1a_i,
	input  logic [2:1] ccbcal_i,
	output logic [5:1] trg_enc_b0_o,
	output logic [5:1] trg_enc_b1_o,
	output logic [5:1] trg_enc_b2_o,
	output logic inj_pulse_o,
	output logic ext_pulse_o,
	output logic ctrl_ready_o
);

	logic core_rst;
	dmb_trig_pkg::lct_vec_t pre_lct;

	trig_cfg_if cfg_if();

	assign pre_lct      = pre_lct_i;
	assign ctrl_ready_o = cfg_if.ctrl_ready;

	//////////////////////////////
	// Reset and registers
	//////////////////////////////

	reset_sequencer u_seq (
		.clkcms       (clkcms),
		.rst          (rst),
		.fpga_ready_i (fpga_ready_i),
		.core_rst_o   (core_rst),
		.cfg          (cfg_if)
	);

	wb_cfg_regs u_regs (
		.clkcms   (clkcms),
		.rst      (rst),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.cfg      (cfg_if)
	);

	//////////////////////////////
	// Trigger path
	//////////////////////////////

	trig_enc_out u_enc (
		.clkcms       (clkcms),
		.rst          (rst),
		.core_rst_i   (core_rst),
		.lct_i        (pre_lct[5:1]),
		.l1a_match_i  (l1a_match_i),
		.l1a_cfeb_i   (l1a_cfeb_i),
		.trg_enc_b0_o (trg_enc_b0_o),
		.trg_enc_b1_o (trg_enc_b1_o),
		.trg_enc_b2_o (trg_enc_b2_o),
		.cfg          (cfg_if)
	);

	// Any-LCT flag starts the timer
	lct_l1a_timer u_timer (
		.clkcms    (clkcms),
		.rst       (rst),
		.lct_any_i (pre_lct[0]),
		.l1a_i     (l1a_i),
		.cfg       (cfg_if)
	);

	// Pin 2 is inject, pin 1 is pulse
	cal_pulse_cond u_cal (
		.clkcms      (clkcms),
		.rst         (rst),
		.core_rst_i  (core_rst),
		.ccbcal_n_i  (ccbcal_i[2:1]),
		.inj_pulse_o (inj_pulse_o),
		.ext_pulse_o (ext_pulse_o),
		.cfg         (cfg_if)
	);

endmodule

// ==== hdl/cal_pulse_cond.sv ====
`timescale 1ns/1ps

module cal_pulse_cond
(
	input  logic clkcms,
	input  logic rst,
	input  logic core_rst_i,
	input  logic [1:0] ccbcal_n_i,
	output logic inj_pulse_o,
	output logic ext_pulse_o,
	trig_cfg_if.cal cfg
);

	logic [1:0] inj_sync;
	logic pls_1, pls_2, pls_q;
	logic core_rst_d;
	logic alt_en;
	logic pls_gate;

	// Lines are active low, bit 1 inject and bit 0 pulse
	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			inj_sync   <= '0;
			pls_1      <= 1'b0;
			pls_2      <= 1'b0;
			pls_q      <= 1'b0;
			core_rst_d <= 1'b0;
		end
		else
		begin
			inj_sync   <= {inj_sync[0], ~ccbcal_n_i[1]};
			pls_1      <= ~ccbcal_n_i[0];
			pls_2      <= pls_1;
			// OR of two stages stretches by one cycle
			pls_q      <= (pls_1 | pls_2) & pls_gate;
			core_rst_d <= core_rst_i;
		end
	end

	// Alternating enable, phase restarts with each core reset
	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
			alt_en <= 1'b0;
		else if (core_rst_i & ~core_rst_d)
			alt_en <= 1'b0;
		else
			alt_en <= ~alt_en;
	end

	assign pls_gate    = alt_en | ~cfg.pulse_alt_en;
	assign inj_pulse_o = inj_sync[1];
	assign ext_pulse_o = pls_q;

endmodule

// ==== hdl/lct_l1a_timer.sv ====
`timescale 1ns/1ps

module lct_l1a_timer
(
	input  logic clkcms,
	input  logic rst,
	input  logic lct_any_i,
	input  logic l1a_i,
	trig_cfg_if.timer cfg
);

	dmb_trig_pkg::timer_state_e state;
	dmb_trig_pkg::tmr_cnt_t count;
	logic count_max;

	assign count_max = (count == 8'hFF);

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			state <= dmb_trig_pkg::IDLE;
			count <= '0;
		end
		else if (cfg.timer_clr)
		begin
			state <= dmb_trig_pkg::IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				dmb_trig_pkg::IDLE:
					// No starts during power-on holdoff
					if (lct_any_i && !cfg.holdoff)
					begin
						state <= dmb_trig_pkg::RUN;
						count <= '0;
					end
				default:
				begin
					// Stop edge still counts, then the value holds
					if (!count_max)
						count <= count + 8'd1;
					if (l1a_i)
						state <= dmb_trig_pkg::IDLE;
				end
			endcase
		end
	end

	assign cfg.timer_val = count;

endmodule

// ==== hdl/trig_enc_out.sv ====
`timescale 1ns/1ps

module trig_enc_out
(
	input  logic clkcms,
	input  logic rst,
	input  logic core_rst_i,
	input  dmb_trig_pkg::cfeb_vec_t lct_i,
	input  dmb_trig_pkg::cfeb_vec_t l1a_match_i,
	input  logic l1a_cfeb_i,
	output dmb_trig_pkg::cfeb_vec_t trg_enc_b0_o,
	output dmb_trig_pkg::cfeb_vec_t trg_enc_b1_o,
	output dmb_trig_pkg::cfeb_vec_t trg_enc_b2_o,
	trig_cfg_if.enc cfg
);

	dmb_trig_pkg::cfeb_vec_t enc0, enc1, enc2;
	dmb_trig_pkg::cfeb_vec_t enc0_d, enc1_d, enc2_d;
	dmb_trig_pkg::cfeb_vec_t sel0, sel1, sel2;

	// Plain mapping: match or LCT, L1A, resync
	assign enc0 = cfg.dcfeb_in_use ? l1a_match_i : lct_i;
	assign enc1 = {5{l1a_cfeb_i}};
	assign enc2 = {5{core_rst_i}};

	// One extra cycle for long cables
	always_ff @(posedge clkcms)
	begin
		enc0_d <= enc0;
		enc1_d <= enc1;
		enc2_d <= enc2;
	end

	assign sel0 = cfg.cable_dly ? enc0_d : enc0;
	assign sel1 = cfg.cable_dly ? enc1_d : enc1;
	assign sel2 = cfg.cable_dly ? enc2_d : enc2;

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			trg_enc_b0_o <= '0;
			trg_enc_b1_o <= '0;
			trg_enc_b2_o <= '0;
		end
		else
		begin
			trg_enc_b0_o <= sel0;
			trg_enc_b1_o <= sel1;
			trg_enc_b2_o <= sel2;
		end
	end

endmodule

// ==== hdl/wb_cfg_regs.sv ====
`timescale 1ns/1ps
`include "dmb_ctrl_macros.svh"

module wb_cfg_regs
(
	input  logic clkcms,
	input  logic rst,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  dmb_cfg_pkg::wb_addr_t wb_adr_i,
	input  dmb_cfg_pkg::wb_data_t wb_dat_i,
	output dmb_cfg_pkg::wb_data_t wb_dat_o,
	output logic wb_ack_o,
	trig_cfg_if.regs cfg
);

	logic acc;
	logic wr_en;
	logic ack_q;
	logic timer_clr_q;
	dmb_cfg_pkg::wb_data_t config_q;
	dmb_cfg_pkg::wb_data_t control_q;
	dmb_cfg_pkg::wb_data_t status_w;
	dmb_cfg_pkg::wb_data_t rd_data;
	dmb_cfg_pkg::wb_data_t dat_q;

	//////////////////////////////
	// Bus handshake
	//////////////////////////////

	// ack_q blocks a second ack while the master still holds strobe
	assign acc   = wb_cyc_i & wb_stb_i & ~ack_q;
	assign wr_en = acc & wb_we_i;

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			ack_q       <= 1'b0;
			timer_clr_q <= 1'b0;
			config_q    <= '0;
			control_q   <= '0;
		end
		else
		begin
			ack_q       <= acc;
			timer_clr_q <= wr_en && (wb_adr_i == `DMB_REG_TIMER);
			if (wr_en)
			begin
				case (wb_adr_i)
					`DMB_REG_CONFIG:
					begin
						config_q[`DMB_CFG_CABLE_DLY] <= wb_dat_i[`DMB_CFG_CABLE_DLY];
						config_q[`DMB_CFG_DCFEB_IN_USE] <= wb_dat_i[`DMB_CFG_DCFEB_IN_USE];
						config_q[`DMB_CFG_PULSE_ALT] <= wb_dat_i[`DMB_CFG_PULSE_ALT];
					end
					`DMB_REG_CONTROL:
						control_q[`DMB_CTL_SOFT_RST] <= wb_dat_i[`DMB_CTL_SOFT_RST];
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////
	// Read back
	//////////////////////////////

	always_comb
	begin
		status_w = '0;
		status_w[`DMB_STA_READY]   = cfg.ctrl_ready;
		status_w[`DMB_STA_HOLDOFF] = cfg.holdoff;
	end

	always_comb
	begin
		case (wb_adr_i)
			`DMB_REG_CONFIG:  rd_data = config_q;
			`DMB_REG_CONTROL: rd_data = control_q;
			`DMB_REG_TIMER:   rd_data = cfg.timer_val;
			`DMB_REG_STATUS:  rd_data = status_w;
			default:          rd_data = '0;
		endcase
	end

	// Captured with the ack, held for its cycle
	always_ff @(posedge clkcms)
	begin
		if (acc)
			dat_q <= rd_data;
	end

	assign wb_dat_o = dat_q;
	assign wb_ack_o = ack_q;

	assign cfg.cable_dly    = config_q[`DMB_CFG_CABLE_DLY];
	assign cfg.dcfeb_in_use = config_q[`DMB_CFG_DCFEB_IN_USE];
	assign cfg.pulse_alt_en = config_q[`DMB_CFG_PULSE_ALT];
	assign cfg.soft_rst     = control_q[`DMB_CTL_SOFT_RST];
	assign cfg.timer_clr    = timer_clr_q;

endmodule

// ==== hdl/reset_sequencer.sv ====
`timescale 1ns/1ps
`include "dmb_ctrl_macros.svh"

module reset_sequencer
(
	input  logic clkcms,
	input  logic rst,
	input  logic fpga_ready_i,
	output logic core_rst_o,
	trig_cfg_if.seq cfg
);

	logic [2:0] rdy_sync;
	logic rdy_rise;
	logic fpga_rst;
	dmb_cfg_pkg::seq_state_e state;
	logic [5:0] seq_cnt;
	logic poh_run;
	logic [7:0] poh_cnt;

	// Two sync stages, third flop only for the edge
	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
			rdy_sync <= '0;
		else
			rdy_sync <= {rdy_sync[1:0], fpga_ready_i};
	end

	assign rdy_rise = rdy_sync[1] & ~rdy_sync[2];

	// Losing clock-ready drops straight back to waiting
	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			state   <= dmb_cfg_pkg::WAIT_READY;
			seq_cnt <= '0;
		end
		else if (!rdy_sync[1])
		begin
			state   <= dmb_cfg_pkg::WAIT_READY;
			seq_cnt <= '0;
		end
		else
		begin
			case (state)
				dmb_cfg_pkg::WAIT_READY:
					if (rdy_rise)
						state <= dmb_cfg_pkg::FPGA_RST;
				dmb_cfg_pkg::FPGA_RST:
				begin
					seq_cnt <= seq_cnt + 6'd1;
					if (seq_cnt == 6'(`DMB_FPGARST_CYCLES - 1))
						state <= dmb_cfg_pkg::CRDY_WAIT;
				end
				dmb_cfg_pkg::CRDY_WAIT:
				begin
					// Count runs on from the reset phase
					seq_cnt <= seq_cnt + 6'd1;
					if (seq_cnt == 6'(`DMB_CRDY_CYCLES - 1))
						state <= dmb_cfg_pkg::READY;
				end
				default:
					state <= dmb_cfg_pkg::READY;
			endcase
		end
	end

	assign fpga_rst = (state == dmb_cfg_pkg::FPGA_RST);

	// Power-on holdoff, restarted by every FPGA reset
	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			poh_run <= 1'b0;
			poh_cnt <= '0;
		end
		else if (fpga_rst)
		begin
			poh_run <= 1'b1;
			poh_cnt <= '0;
		end
		else if (poh_run)
		begin
			poh_cnt <= poh_cnt + 8'd1;
			if (poh_cnt == 8'(`DMB_POH_CYCLES - 1))
				poh_run <= 1'b0;
		end
	end

	assign cfg.holdoff    = fpga_rst | poh_run;
	assign cfg.ctrl_ready = (state == dmb_cfg_pkg::READY);
	assign core_rst_o     = rst | fpga_rst | cfg.soft_rst;

endmodule

// ==== hdl/trig_cfg_if.sv ====
`timescale 1ns/1ps

interface trig_cfg_if;

	// Configuration from the register block
	logic cable_dly;
	logic dcfeb_in_use;
	logic pulse_alt_en;
	logic soft_rst;
	logic timer_clr;

	// Status back to the register block
	dmb_trig_pkg::tmr_cnt_t timer_val;
	logic holdoff;
	logic ctrl_ready;

	modport regs (
		output cable_dly, dcfeb_in_use, pulse_alt_en, soft_rst, timer_clr,
		input  timer_val, holdoff, ctrl_ready
	);
	modport enc (input cable_dly, dcfeb_in_use);
	modport cal (input pulse_alt_en);
	modport timer (input timer_clr, holdoff, output timer_val);
	modport seq (input soft_rst, output holdoff, ctrl_ready);

endinterface

// ==== hdl/dmb_trig_pkg.sv ====
package dmb_trig_pkg;

	// One bit per front-end board
	typedef logic [4:0] cfeb_vec_t;

	// Pre-LCT bus, bit 0 is the any-LCT flag
	typedef logic [5:0] lct_vec_t;

	// LCT to L1A interval
	typedef logic [7:0] tmr_cnt_t;

	// Timer phases
	typedef enum logic
	{
		IDLE,
		RUN
	} timer_state_e;

endpackage

// ==== hdl/dmb_cfg_pkg.sv ====
package dmb_cfg_pkg;

	// Register bus address, 16 locations
	typedef logic [3:0] wb_addr_t;

	// Register bus data
	typedef logic [7:0] wb_data_t;

	// Reset sequencer phases
	typedef enum logic [1:0]
	{
		WAIT_READY,
		FPGA_RST,
		CRDY_WAIT,
		READY
	} seq_state_e;

endpackage

// ==== hdl/dmb_ctrl_macros.svh ====
`ifndef DMB_CTRL_MACROS_SVH
`define DMB_CTRL_MACROS_SVH

// Reset sequencer cycle counts
`define DMB_FPGARST_CYCLES 16
`define DMB_CRDY_CYCLES 32
`define DMB_POH_CYCLES 64

// Register map
`define DMB_REG_CONFIG 4'd0
`define DMB_REG_CONTROL 4'd1
`define DMB_REG_TIMER 4'd2
`define DMB_REG_STATUS 4'd3

// CONFIG bits
`define DMB_CFG_CABLE_DLY 0
`define DMB_CFG_DCFEB_IN_USE 1
`define DMB_CFG_PULSE_ALT 2

// CONTROL and STATUS bits
`define DMB_CTL_SOFT_RST 0
`define DMB_STA_READY 0
`define DMB_STA_HOLDOFF 1

`endif
